/* run_sim.sh */
#!/bin/sh
# Build the processor testbench with Verilator, run it, and scan the log.

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module processor_tb \
	-f vlog.f -o processor_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	echo "Verilator build failed, see $BUILD_LOG"
	exit 1
fi

./obj_dir/processor_sim > "$SIM_LOG" 2>&1
run_status=$?
cat "$SIM_LOG"

if grep -q "SIMULATION FAILED" "$SIM_LOG"; then
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi
exit 0

/* source/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  core_pkg::word_t  a,
	input  core_pkg::word_t  b,
	input  isa_pkg::alu_op_e op,
	output core_pkg::word_t  result,
	output core_pkg::flags_t flags
);

	logic [32:0] sum;
	logic [32:0] diff;
	logic [4:0]  shamt;

	assign sum   = {1'b0, a} + {1'b0, b};
	assign diff  = {1'b0, a} - {1'b0, b};
	assign shamt = b[4:0];

	always_comb begin
		result  = '0;
		flags.c = 1'b0;
		flags.o = 1'b0;
		case (op)
			isa_pkg::ALU_ADD: begin
				result  = sum[31:0];
				flags.c = sum[32];
				flags.o = (a[31] == b[31]) && (sum[31] != a[31]);
			end
			isa_pkg::ALU_SUB: begin
				result  = diff[31:0];
				flags.c = ~diff[32]; // no borrow.
				flags.o = (a[31] != b[31]) && (diff[31] != a[31]);
			end
			isa_pkg::ALU_AND: result = a & b;
			isa_pkg::ALU_OR:  result = a | b;
			isa_pkg::ALU_XOR: result = a ^ b;
			isa_pkg::ALU_SHL: result = a << shamt;
			isa_pkg::ALU_SHR: result = a >> shamt; // logical.
			default: result = '0;
		endcase
	end

	assign flags.s = result[31];
	assign flags.z = (result == '0);

endmodule

`default_nettype wire

/* source/control_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module control_unit (
	input  logic              clk,
	input  logic              reset,
	input  logic              run,
	input  isa_pkg::instr_t   instr,
	input  logic              cond_true,
	output logic              load_en,
	output logic              imem_re,
	output logic              pc_we,
	output logic              branch_taken,
	output isa_pkg::alu_op_e  alu_op,
	output logic              use_imm,
	output logic              flags_we,
	output logic              dmem_we,
	output logic              dmem_re,
	output logic              reg_we,
	output isa_pkg::wb_sel_e  wb_sel,
	output logic              busy,
	output logic              halted
);

	typedef enum logic [2:0] {IDLE, FETCH, EXEC, MEM, HALT} state_e;

	state_e state;
	state_e state_next;
	logic   writes_reg;
	logic   is_branch;
	logic   exec;

	// ********************
	// sequencer
	// ********************
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			IDLE:  if (run) state_next = FETCH;
			FETCH: state_next = EXEC;
			EXEC: begin
				case (instr.opcode)
					isa_pkg::OP_LW:   state_next = MEM;
					isa_pkg::OP_HALT: state_next = HALT;
					default:          state_next = FETCH;
				endcase
			end
			MEM:   state_next = FETCH;
			HALT:  state_next = HALT; // left only through reset.
			default: state_next = IDLE;
		endcase
	end

	// ********************
	// decoder
	// ********************
	always_comb begin
		alu_op     = isa_pkg::ALU_ADD;
		use_imm    = 1'b0;
		wb_sel     = isa_pkg::WB_ALU;
		writes_reg = 1'b0;
		is_branch  = 1'b0;
		case (instr.opcode)
			isa_pkg::OP_ALU: begin
				alu_op     = isa_pkg::alu_op_e'(instr.imm[2:0]);
				writes_reg = 1'b1;
			end
			isa_pkg::OP_ADDI: begin
				use_imm    = 1'b1;
				writes_reg = 1'b1;
			end
			isa_pkg::OP_LW: begin
				use_imm = 1'b1;
				wb_sel  = isa_pkg::WB_MEM; // written back from MEM.
			end
			isa_pkg::OP_SW: use_imm = 1'b1;
			isa_pkg::OP_BR: is_branch = 1'b1;
			default: ;
		endcase
	end

	assign exec         = (state == EXEC);
	assign load_en      = (state == IDLE) || (state == HALT);
	assign imem_re      = (state == FETCH);
	assign pc_we        = exec && (instr.opcode != isa_pkg::OP_HALT);
	assign branch_taken = exec && is_branch && cond_true;
	// register-register add and sub only, addi leaves the flags alone.
	assign flags_we     = exec && (instr.opcode == isa_pkg::OP_ALU) &&
		(alu_op == isa_pkg::ALU_ADD || alu_op == isa_pkg::ALU_SUB);
	assign dmem_we      = exec && (instr.opcode == isa_pkg::OP_SW);
	assign dmem_re      = exec && (instr.opcode == isa_pkg::OP_LW);
	assign reg_we       = (instr.rd != '0) && ((exec && writes_reg) || (state == MEM));
	assign busy         = (state == FETCH) || exec || (state == MEM);
	assign halted       = (state == HALT);

endmodule

`default_nettype wire

/* source/core_pkg.sv */
`default_nettype none

package core_pkg;

	typedef logic [31:0] word_t;

	localparam int IMEM_DEPTH = 256;
	localparam int DMEM_DEPTH = 256;
	localparam int IMEM_AW    = 8;
	localparam int DMEM_AW    = 8;
	localparam int REG_AW     = 5;

	// overflow, sign, carry, zero.
	typedef struct packed {
		logic o;
		logic s;
		logic c;
		logic z;
	} flags_t;

endpackage

`default_nettype wire

/* source/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         load_en,
	input  logic                         load_req,
	input  logic [core_pkg::IMEM_AW-1:0] load_addr,
	input  isa_pkg::instr_t              load_data,
	input  logic                         imem_re,
	input  logic                         pc_we,
	input  logic                         branch_taken,
	output logic                         load_ack,
	output isa_pkg::instr_t              instr
);

	logic [core_pkg::IMEM_AW-1:0] pc;
	logic [core_pkg::IMEM_AW-1:0] pc_next;
	logic [core_pkg::IMEM_AW-1:0] ram_addr;
	logic                         load_fire;

	// host write accepted only while the core is idle.
	assign load_fire = load_en && load_req && !load_ack;
	assign ram_addr  = load_fire ? load_addr : pc;

	// branch offset wraps within the instruction memory.
	assign pc_next = branch_taken ? pc + instr.imm[core_pkg::IMEM_AW-1:0] : pc + 1'b1;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else if (pc_we) begin
			pc <= pc_next;
		end
	end

	// four-phase handshake.
	always_ff @(posedge clk) begin
		if (reset) begin
			load_ack <= 1'b0;
		end else if (load_fire) begin
			load_ack <= 1'b1;
		end else if (!load_req) begin
			load_ack <= 1'b0;
		end
	end

	sync_ram #(
		.payload_t(isa_pkg::instr_t),
		.depth    (core_pkg::IMEM_DEPTH)
	) imem_inst (
		.clk  (clk),
		.reset(reset),
		.we   (load_fire),
		.re   (imem_re),
		.addr (ram_addr),
		.wdata(load_data),
		.rdata(instr)
	);

endmodule

`default_nettype wire

/* source/flag_test.sv */
`timescale 1ns/1ps
`default_nettype none

module flag_test (
	input  logic             clk,
	input  logic             reset,
	input  logic             flags_we,
	input  core_pkg::flags_t flags_in,
	input  isa_pkg::cond_e   cond,
	output logic             cond_true
);

	core_pkg::flags_t flags;

	always_ff @(posedge clk) begin
		if (reset) begin
			flags <= '0;
		end else if (flags_we) begin
			flags <= flags_in;
		end
	end

	// ********************
	// condition table
	// ********************
	always_comb begin
		case (cond)
			isa_pkg::C_ALWAYS: cond_true = 1'b1;
			isa_pkg::C_EQ:     cond_true = flags.z;
			isa_pkg::C_NE:     cond_true = ~flags.z;
			isa_pkg::C_LT:     cond_true = flags.s ^ flags.o;
			isa_pkg::C_GE:     cond_true = ~(flags.s ^ flags.o);
			isa_pkg::C_CS:     cond_true = flags.c;
			isa_pkg::C_NEG:    cond_true = flags.s;
			default:           cond_true = 1'b0; // never.
		endcase
	end

endmodule

`default_nettype wire

/* source/isa_pkg.sv */
`default_nettype none

package isa_pkg;

	// ********************
	// opcodes
	// ********************
	// any value not listed runs as a no-op.
	typedef enum logic [5:0] {
		OP_ALU  = 6'h01,
		OP_ADDI = 6'h02,
		OP_LW   = 6'h03,
		OP_SW   = 6'h04,
		OP_BR   = 6'h05,
		OP_HALT = 6'h3f
	} opcode_e;

	// rb sits in imm[15:11], the alu selector of OP_ALU in imm[2:0].
	typedef struct packed {
		opcode_e            opcode;
		logic [4:0]         rd; // branch condition in rd[2:0].
		logic [4:0]         ra;
		logic signed [15:0] imm;
	} instr_t;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SHL = 3'd5,
		ALU_SHR = 3'd6
	} alu_op_e;

	// ********************
	// branch conditions
	// ********************
	typedef enum logic [2:0] {
		C_ALWAYS = 3'd0,
		C_EQ     = 3'd1, // z.
		C_NE     = 3'd2, // not z.
		C_LT     = 3'd3, // s xor o.
		C_GE     = 3'd4, // not (s xor o).
		C_CS     = 3'd5, // c.
		C_NEG    = 3'd6, // s.
		C_NEVER  = 3'd7
	} cond_e;

	typedef enum logic {
		WB_ALU = 1'b0,
		WB_MEM = 1'b1
	} wb_sel_e;

endpackage

`default_nettype wire

/* source/processor.sv */
`timescale 1ns/1ps
`default_nettype none

module processor (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         load_req,
	input  logic [core_pkg::IMEM_AW-1:0] load_addr,
	input  isa_pkg::instr_t              load_data,
	input  logic                         run,
	output logic                         load_ack,
	output logic                         busy,
	output logic                         halted,
	output logic                         reg_we,
	output logic [core_pkg::REG_AW-1:0]  reg_addr,
	output core_pkg::word_t              reg_data
);

	isa_pkg::instr_t             instr;
	isa_pkg::alu_op_e            alu_op;
	isa_pkg::wb_sel_e            wb_sel;
	logic                        load_en;
	logic                        imem_re;
	logic                        pc_we;
	logic                        branch_taken;
	logic                        use_imm;
	logic                        flags_we;
	logic                        dmem_we;
	logic                        dmem_re;
	logic                        cond_true;
	logic [core_pkg::REG_AW-1:0] rb_addr;
	core_pkg::word_t             ra_data;
	core_pkg::word_t             rb_data;
	core_pkg::word_t             imm_ext;
	core_pkg::word_t             alu_b;
	core_pkg::word_t             alu_result;
	core_pkg::word_t             dmem_rdata;
	core_pkg::flags_t            alu_flags;

	// ********************
	// datapath wiring
	// ********************
	assign imm_ext = {{16{instr.imm[15]}}, instr.imm};
	assign alu_b   = use_imm ? imm_ext : rb_data;
	// immediate forms read rd on port b, which is the store data.
	assign rb_addr  = use_imm ? instr.rd : instr.imm[15:11];
	assign reg_addr = instr.rd;
	assign reg_data = (wb_sel == isa_pkg::WB_MEM) ? dmem_rdata : alu_result;

	control_unit control_unit_inst (
		.clk         (clk),
		.reset       (reset),
		.run         (run),
		.instr       (instr),
		.cond_true   (cond_true),
		.load_en     (load_en),
		.imem_re     (imem_re),
		.pc_we       (pc_we),
		.branch_taken(branch_taken),
		.alu_op      (alu_op),
		.use_imm     (use_imm),
		.flags_we    (flags_we),
		.dmem_we     (dmem_we),
		.dmem_re     (dmem_re),
		.reg_we      (reg_we),
		.wb_sel      (wb_sel),
		.busy        (busy),
		.halted      (halted)
	);

	fetch_unit fetch_unit_inst (
		.clk         (clk),
		.reset       (reset),
		.load_en     (load_en),
		.load_req    (load_req),
		.load_addr   (load_addr),
		.load_data   (load_data),
		.imem_re     (imem_re),
		.pc_we       (pc_we),
		.branch_taken(branch_taken),
		.load_ack    (load_ack),
		.instr       (instr)
	);

	register_bank register_bank_inst (
		.clk    (clk),
		.reset  (reset),
		.ra_addr(instr.ra),
		.rb_addr(rb_addr),
		.wr_en  (reg_we),
		.wr_addr(reg_addr),
		.wr_data(reg_data),
		.ra_data(ra_data),
		.rb_data(rb_data)
	);

	alu alu_inst (
		.a     (ra_data),
		.b     (alu_b),
		.op    (alu_op),
		.result(alu_result),
		.flags (alu_flags)
	);

	flag_test flag_test_inst (
		.clk      (clk),
		.reset    (reset),
		.flags_we (flags_we),
		.flags_in (alu_flags),
		.cond     (isa_pkg::cond_e'(instr.rd[2:0])),
		.cond_true(cond_true)
	);

	sync_ram #(
		.payload_t(core_pkg::word_t),
		.depth    (core_pkg::DMEM_DEPTH)
	) dmem_inst (
		.clk  (clk),
		.reset(reset),
		.we   (dmem_we),
		.re   (dmem_re),
		.addr (alu_result[core_pkg::DMEM_AW-1:0]), // word address.
		.wdata(rb_data),
		.rdata(dmem_rdata)
	);

endmodule

`default_nettype wire

/* source/register_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module register_bank (
	input  logic                        clk,
	input  logic                        reset,
	input  logic [core_pkg::REG_AW-1:0] ra_addr,
	input  logic [core_pkg::REG_AW-1:0] rb_addr,
	input  logic                        wr_en,
	input  logic [core_pkg::REG_AW-1:0] wr_addr,
	input  core_pkg::word_t             wr_data,
	output core_pkg::word_t             ra_data,
	output core_pkg::word_t             rb_data
);

	localparam int NREGS = 2 ** core_pkg::REG_AW;

	core_pkg::word_t regs [NREGS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// r0 reads as zero.
	assign ra_data = (ra_addr == '0) ? '0 : regs[ra_addr];
	assign rb_data = (rb_addr == '0) ? '0 : regs[rb_addr];

endmodule

`default_nettype wire

/* source/sync_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_ram #(
	parameter type payload_t = core_pkg::word_t,
	parameter int  depth     = 256
) (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     we,
	input  logic                     re,
	input  logic [$clog2(depth)-1:0] addr,
	input  payload_t                 wdata,
	output payload_t                 rdata
);

	payload_t mem [depth];

	// contents start at zero.
	initial begin
		for (int i = 0; i < depth; i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rdata <= '0;
		end else if (re) begin
			rdata <= mem[addr]; // held while re is low.
		end
	end

endmodule

`default_nettype wire

/* test/processor_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module processor_chk (
	input logic clk,
	input logic reset,
	input logic load_req,
	input logic load_ack,
	input logic reg_we,
	input logic halted
);

	// ********************
	// load handshake
	// ********************
	ack_rise: assert property (@(posedge clk) disable iff (reset)
		$rose(load_ack) |-> $past(load_req))
		else $error("load_ack rose with no load_req");

	ack_fall: assert property (@(posedge clk) disable iff (reset)
		$fell(load_ack) |-> !$past(load_req))
		else $error("load_ack fell while load_req was high");

	// ********************
	// control
	// ********************
	we_single: assert property (@(posedge clk) disable iff (reset)
		reg_we |=> !reg_we)
		else $error("reg_we high in two consecutive cycles");

	halt_held: assert property (@(posedge clk)
		$fell(halted) |-> $past(reset))
		else $error("halted fell without reset");

endmodule

`default_nettype wire

/* test/processor_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module processor_tb;

	logic                         clk;
	logic                         reset;
	logic                         load_req;
	logic [core_pkg::IMEM_AW-1:0] load_addr;
	isa_pkg::instr_t              load_data;
	logic                         run;
	logic                         load_ack;
	logic                         busy;
	logic                         halted;
	logic                         reg_we;
	logic [core_pkg::REG_AW-1:0]  reg_addr;
	core_pkg::word_t              reg_data;

	isa_pkg::instr_t             prog [$];
	logic [core_pkg::REG_AW-1:0] exp_addr [$];
	core_pkg::word_t             exp_data [$];
	isa_pkg::instr_t             model_imem [core_pkg::IMEM_DEPTH];
	core_pkg::word_t             model_dmem [core_pkg::DMEM_DEPTH];
	logic [31:0]                 lcg_state = 32'hd573_852f;
	int                          cycles = 0;
	int                          budget = 200; // grows with every program loaded and run.

	tb_clock clock_inst (
		.clk(clk)
	);

	processor processor_inst (
		.clk      (clk),
		.reset    (reset),
		.load_req (load_req),
		.load_addr(load_addr),
		.load_data(load_data),
		.run      (run),
		.load_ack (load_ack),
		.busy     (busy),
		.halted   (halted),
		.reg_we   (reg_we),
		.reg_addr (reg_addr),
		.reg_data (reg_data)
	);

	bind processor processor_chk processor_chk_inst (
		.clk     (clk),
		.reset   (reset),
		.load_req(load_req),
		.load_ack(load_ack),
		.reg_we  (reg_we),
		.halted  (halted)
	);

	function automatic logic [31:0] rand_word();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic isa_pkg::instr_t encode(isa_pkg::opcode_e op, logic [4:0] rd,
		logic [4:0] ra, logic [15:0] imm);
		isa_pkg::instr_t w;
		w.opcode = op;
		w.rd     = rd;
		w.ra     = ra;
		w.imm    = imm;
		return w;
	endfunction

	function automatic isa_pkg::instr_t alu_instr(isa_pkg::alu_op_e op, logic [4:0] rd,
		logic [4:0] ra, logic [4:0] rb);
		return encode(isa_pkg::OP_ALU, rd, ra, {rb, 8'h00, op});
	endfunction

	function automatic isa_pkg::instr_t branch_instr(isa_pkg::cond_e cond, logic [15:0] offset);
		return encode(isa_pkg::OP_BR, {2'b00, cond}, 5'd0, offset);
	endfunction

	task automatic fail_run();
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	// ********************
	// checks
	// ********************
	task automatic check_write(input logic [core_pkg::REG_AW-1:0] addr,
		input core_pkg::word_t data);
		if (reg_addr !== addr) begin
			$display("Error: reg_addr is %h, expected %h", reg_addr, addr);
			fail_run();
		end
		if (reg_data !== data) begin
			$display("Error: reg_data is %h, expected %h", reg_data, data);
			fail_run();
		end
	endtask

	task automatic check_flag_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error: %s is %h, expected %h", name, got, exp);
			fail_run();
		end
	endtask

	// ********************
	// reference model
	// ********************
	task automatic alu_ref(input logic [2:0] op, input core_pkg::word_t a,
		input core_pkg::word_t b, output core_pkg::word_t res, inout core_pkg::flags_t fl);
		longint exact;
		exact = 0;
		case (op)
			3'd0: begin
				res   = a + b;
				exact = longint'($signed(a)) + longint'($signed(b));
				fl.c  = ({32'd0, a} + {32'd0, b}) > 64'hffff_ffff;
			end
			3'd1: begin
				res   = a - b;
				exact = longint'($signed(a)) - longint'($signed(b));
				fl.c  = (a >= b); // no borrow.
			end
			3'd2: res = a & b;
			3'd3: res = a | b;
			3'd4: res = a ^ b;
			3'd5: res = a << b[4:0];
			3'd6: res = a >> b[4:0];
			default: res = '0;
		endcase
		if (op <= 3'd1) begin
			fl.o = (exact != longint'($signed(res)));
			fl.s = res[31];
			fl.z = (res == '0);
		end
	endtask

	task automatic model_run(output int steps);
		core_pkg::word_t  rf [32];
		core_pkg::flags_t fl;
		isa_pkg::instr_t  w;
		core_pkg::word_t  a;
		core_pkg::word_t  res;
		logic [7:0]       pc;
		logic             wr;
		logic             take;
		logic             done;
		foreach (rf[i]) begin
			rf[i] = '0;
		end
		fl    = '0;
		pc    = '0;
		done  = 1'b0;
		steps = 0;
		exp_addr.delete();
		exp_data.delete();
		while (!done) begin
			w    = model_imem[pc];
			a    = rf[w.ra];
			res  = a + {{16{w.imm[15]}}, w.imm};
			wr   = 1'b0;
			take = 1'b0;
			steps++;
			case (w.opcode)
				isa_pkg::OP_ALU: begin
					alu_ref(w.imm[2:0], a, rf[w.imm[15:11]], res, fl);
					wr = 1'b1;
				end
				isa_pkg::OP_ADDI: wr = 1'b1;
				isa_pkg::OP_LW: begin
					res = model_dmem[res[7:0]];
					wr  = 1'b1;
				end
				isa_pkg::OP_SW:   model_dmem[res[7:0]] = rf[w.rd];
				isa_pkg::OP_HALT: done = 1'b1;
				isa_pkg::OP_BR: begin
					case (isa_pkg::cond_e'(w.rd[2:0]))
						isa_pkg::C_ALWAYS: take = 1'b1;
						isa_pkg::C_EQ:     take = fl.z;
						isa_pkg::C_NE:     take = !fl.z;
						isa_pkg::C_LT:     take = fl.s ^ fl.o;
						isa_pkg::C_GE:     take = !(fl.s ^ fl.o);
						isa_pkg::C_CS:     take = fl.c;
						isa_pkg::C_NEG:    take = fl.s;
						default:           take = 1'b0;
					endcase
				end
				default: ;
			endcase
			pc = pc + (take ? w.imm[7:0] : 8'd1);
			if (wr && w.rd != '0) begin
				rf[w.rd] = res;
				exp_addr.push_back(w.rd);
				exp_data.push_back(res);
			end
			if (steps > 4000) begin
				$display("reference model ran 4000 steps without reaching halt");
				fail_run();
			end
		end
	endtask

	// ********************
	// host side
	// ********************
	task automatic reset_core();
		@(negedge clk);
		reset = 1'b1;
		repeat (2) @(negedge clk);
		reset = 1'b0;
	endtask

	task automatic load_word(input logic [core_pkg::IMEM_AW-1:0] addr,
		input isa_pkg::instr_t word);
		@(negedge clk);
		check_flag_bit("load_ack", load_ack, 1'b0);
		load_addr = addr;
		load_data = word;
		load_req  = 1'b1;
		do begin
			@(negedge clk);
		end while (!load_ack);
		model_imem[addr] = word;
		load_req = 1'b0;
		do begin
			@(negedge clk);
		end while (load_ack);
	endtask

	task automatic load_program();
		budget += prog.size() * 6 + 20;
		foreach (prog[i]) begin
			load_word(8'(i), prog[i]);
		end
	endtask

	task automatic run_program(input bit probe_load);
		int              steps;
		isa_pkg::instr_t park;
		model_run(steps);
		budget += steps * 3 + 30;
		park = encode(isa_pkg::OP_HALT, 5'd0, 5'd0, 16'h0000);
		@(negedge clk);
		run = 1'b1;
		@(negedge clk);
		run = 1'b0;
		if (probe_load) begin
			load_addr = 8'd250; // past every program.
			load_data = park;
			load_req  = 1'b1;
		end
		while (!halted) begin
			check_flag_bit("busy", busy, 1'b1);
			if (probe_load) begin
				check_flag_bit("load_ack", load_ack, 1'b0);
			end
			if (reg_we) begin
				if (exp_addr.size() == 0) begin
					$display("register write to r%0d when no write was expected", reg_addr);
					fail_run();
				end
				check_write(exp_addr.pop_front(), exp_data.pop_front());
			end
			@(negedge clk);
		end
		check_flag_bit("busy", busy, 1'b0);
		if (exp_addr.size() != 0) begin
			$display("halted early, %0d expected register writes never came", exp_addr.size());
			fail_run();
		end
		if (probe_load) begin
			while (!load_ack) @(negedge clk); // accepted once the core halts.
			model_imem[250] = park;
			load_req = 1'b0;
			while (load_ack) @(negedge clk);
		end
	endtask

	task automatic push_cond_probe(input isa_pkg::cond_e cond, input int marker);
		prog.push_back(branch_instr(cond, 16'd2));
		prog.push_back(encode(isa_pkg::OP_ADDI, 5'd20, 5'd0, 16'(marker)));
	endtask

	// ********************
	// directed tests
	// ********************
	task automatic alu_ops();
		core_pkg::word_t r;
		reset_core();
		prog.delete();
		for (int i = 1; i <= 3; i++) begin
			r = rand_word();
			prog.push_back(encode(isa_pkg::OP_ADDI, 5'(i), 5'd0, r[15:0]));
		end
		for (int op = 0; op < 7; op++) begin
			prog.push_back(alu_instr(isa_pkg::alu_op_e'(op), 5'(4 + op), 5'd1,
				(op >= 5) ? 5'd3 : 5'd2)); // r3 holds the shift amount.
		end
		prog.push_back(alu_instr(isa_pkg::ALU_ADD, 5'd0, 5'd1, 5'd2));
		prog.push_back(encode(isa_pkg::OP_ADDI, 5'd0, 5'd1, 16'h0040));
		prog.push_back(alu_instr(isa_pkg::ALU_OR, 5'd11, 5'd0, 5'd1));
		prog.push_back(encode(isa_pkg::OP_HALT, 5'd0, 5'd0, 16'h0000));
		load_program();
		run_program(1'b0);
	endtask

	task automatic memory_access();
		core_pkg::word_t r;
		reset_core();
		prog.delete();
		r = rand_word();
		prog.push_back(encode(isa_pkg::OP_ADDI, 5'd1, 5'd0, r[15:0]));
		prog.push_back(encode(isa_pkg::OP_ADDI, 5'd2, 5'd0, 16'd16));
		prog.push_back(alu_instr(isa_pkg::ALU_SHL, 5'd1, 5'd1, 5'd2));
		r = rand_word();
		prog.push_back(encode(isa_pkg::OP_ADDI, 5'd3, 5'd0, r[15:0]));
		prog.push_back(alu_instr(isa_pkg::ALU_XOR, 5'd1, 5'd1, 5'd3));
		r = rand_word();
		prog.push_back(encode(isa_pkg::OP_ADDI, 5'd4, 5'd0, {8'h00, r[7:0]}));
		prog.push_back(encode(isa_pkg::OP_SW, 5'd1, 5'd4, 16'd3));
		prog.push_back(encode(isa_pkg::opcode_e'(6'h10), 5'd9, 5'd9, 16'h1234)); // no-op.
		prog.push_back(encode(isa_pkg::OP_LW, 5'd5, 5'd4, 16'd3));
		prog.push_back(encode(isa_pkg::OP_HALT, 5'd0, 5'd0, 16'h0000));
		load_program();
		run_program(1'b0);
	endtask

	task automatic branch_conditions();
		reset_core();
		prog.delete();
		prog.push_back(encode(isa_pkg::OP_ADDI, 5'd1, 5'd0, 16'd1));
		prog.push_back(encode(isa_pkg::OP_ADDI, 5'd2, 5'd0, 16'd2));
		prog.push_back(encode(isa_pkg::OP_ADDI, 5'd4, 5'd0, 16'hffff));
		prog.push_back(alu_instr(isa_pkg::ALU_SHR, 5'd3, 5'd4, 5'd1)); // 7fffffff.
		prog.push_back(alu_instr(isa_pkg::ALU_SUB, 5'd10, 5'd1, 5'd1)); // z and c.
		prog.push_back(alu_instr(isa_pkg::ALU_OR, 5'd11, 5'd1, 5'd2));
		push_cond_probe(isa_pkg::C_EQ, 1);
		push_cond_probe(isa_pkg::C_NE, 2);
		push_cond_probe(isa_pkg::C_CS, 3);
		push_cond_probe(isa_pkg::C_NEG, 4);
		push_cond_probe(isa_pkg::C_ALWAYS, 5);
		push_cond_probe(isa_pkg::C_NEVER, 6);
		prog.push_back(alu_instr(isa_pkg::ALU_SUB, 5'd10, 5'd1, 5'd2)); // s only.
		prog.push_back(alu_instr(isa_pkg::ALU_AND, 5'd11, 5'd1, 5'd2)); // zero, flags kept.
		push_cond_probe(isa_pkg::C_EQ, 7);
		push_cond_probe(isa_pkg::C_NE, 8);
		push_cond_probe(isa_pkg::C_LT, 9);
		push_cond_probe(isa_pkg::C_GE, 10);
		push_cond_probe(isa_pkg::C_CS, 11);
		push_cond_probe(isa_pkg::C_NEG, 12);
		prog.push_back(alu_instr(isa_pkg::ALU_ADD, 5'd10, 5'd3, 5'd1)); // s and o.
		push_cond_probe(isa_pkg::C_LT, 13);
		push_cond_probe(isa_pkg::C_GE, 14);
		prog.push_back(encode(isa_pkg::OP_ADDI, 5'd5, 5'd0, 16'd5));
		prog.push_back(alu_instr(isa_pkg::ALU_SUB, 5'd5, 5'd5, 5'd1)); // countdown loop.
		prog.push_back(branch_instr(isa_pkg::C_NE, 16'hffff));
		prog.push_back(encode(isa_pkg::OP_HALT, 5'd0, 5'd0, 16'h0000));
		load_program();
		run_program(1'b1);
	endtask

	task automatic halt_and_reset();
		core_pkg::word_t r;
		reset_core();
		prog.delete();
		r = rand_word();
		prog.push_back(encode(isa_pkg::OP_ADDI, 5'd1, 5'd0, r[15:0]));
		r = rand_word();
		prog.push_back(encode(isa_pkg::OP_ADDI, 5'd2, 5'd1, r[15:0]));
		prog.push_back(encode(isa_pkg::OP_SW, 5'd2, 5'd0, 16'd7));
		prog.push_back(encode(isa_pkg::OP_LW, 5'd3, 5'd0, 16'd7));
		prog.push_back(alu_instr(isa_pkg::ALU_ADD, 5'd4, 5'd3, 5'd1));
		prog.push_back(encode(isa_pkg::OP_HALT, 5'd0, 5'd0, 16'h0000));
		load_program();
		run_program(1'b0);
		budget += 10;
		repeat (4) begin
			@(negedge clk);
			check_flag_bit("halted", halted, 1'b1);
			if (reg_we) begin
				$display("register write seen after the core halted");
				fail_run();
			end
		end
		reset_core();
		check_flag_bit("halted", halted, 1'b0);
		check_flag_bit("load_ack", load_ack, 1'b0);
		check_flag_bit("busy", busy, 1'b0);
		run_program(1'b0); // same program again from pc 0.
	endtask

	initial begin
		reset     = 1'b1;
		load_req  = 1'b0;
		load_addr = '0;
		load_data = '0;
		run       = 1'b0;
		foreach (model_imem[i]) begin
			model_imem[i] = '0;
		end
		foreach (model_dmem[i]) begin
			model_dmem[i] = '0;
		end
		repeat (2) @(negedge clk);
		reset = 1'b0;
		alu_ops();
		memory_access();
		branch_conditions();
		halt_and_reset();
		$display("SIMULATION PASSED");
		$finish;
	end

	// watchdog.
	initial begin
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles > budget) begin
				$display("watchdog expired after %0d cycles, the DUT stopped responding", cycles);
				fail_run();
			end
		end
	end

endmodule

`default_nettype wire

/* test/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic clk
);

	localparam time HALF_PERIOD = 10ns; // 20 ns period.

	initial begin
		clk = 1'b0;
		forever begin
			#HALF_PERIOD clk = ~clk;
		end
	end

endmodule

`default_nettype wire

/* vlog.f */
source/core_pkg.sv
source/isa_pkg.sv
source/sync_ram.sv
source/alu.sv
source/register_bank.sv
source/flag_test.sv
source/control_unit.sv
source/fetch_unit.sv
source/processor.sv
test/tb_clock.sv
test/processor_chk.sv
test/processor_tb.sv
